//--- common/ctrlPkg.sv
package ctrlPkg;

    localparam int instWidth  = 16;
    localparam int opWidth    = 5;
    localparam int functWidth = 2;

    // Major opcode in inst[15:11]
    typedef enum logic [opWidth-1:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        ILLOP = 5'b00010,
        RTI   = 5'b00011,
        JDIS  = 5'b00100,
        JR    = 5'b00101,
        JALC  = 5'b00110,
        JALR  = 5'b00111,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        BLTZ  = 5'b01110,
        BGEZ  = 5'b01111,
        ST    = 5'b10000,
        LD    = 5'b10001,
        SLBI  = 5'b10010,
        STU   = 5'b10011,
        ROLI  = 5'b10100,
        SLLI  = 5'b10101,
        RORI  = 5'b10110,
        SRLI  = 5'b10111,
        LBI   = 5'b11000,
        BTR   = 5'b11001,
        SALU  = 5'b11010,
        BALU  = 5'b11011,
        SEQ   = 5'b11100,
        SLT   = 5'b11101,
        SLE   = 5'b11110,
        SCO   = 5'b11111
    } opcode_e;

    // ALU operation select with code 6 unused
    typedef enum logic [3:0] {
        ALU_ROL  = 4'd0,
        ALU_SLL  = 4'd1,
        ALU_ROR  = 4'd2,
        ALU_SRL  = 4'd3,
        ALU_ADD  = 4'd4,
        ALU_ANDN = 4'd5,
        ALU_XOR  = 4'd7,
        ALU_SLBI = 4'd8,
        ALU_SUB  = 4'd9,
        ALU_SEQ  = 4'd10,
        ALU_SLT  = 4'd11,
        ALU_SLE  = 4'd12,
        ALU_SCO  = 4'd13,
        ALU_BTR  = 4'd14,
        ALU_LBI  = 4'd15
    } aluOp_e;

    // R-format function field in inst[1:0]
    // Names give the BALU meaning first, then the SALU one
    typedef enum logic [functWidth-1:0] {
        FN_ADD_ROL  = 2'd0,
        FN_SUB_SLL  = 2'd1,
        FN_XOR_ROR  = 2'd2,
        FN_ANDN_SRL = 2'd3
    } aluFunct_e;

    typedef enum logic [1:0] {
        PC_OLD    = 2'd0,
        PC_INC    = 2'd1,
        PC_TARGET = 2'd2, // Branch or jump address
        PC_EPC    = 2'd3
    } pcSrc_e;

    typedef enum logic [1:0] {
        DST_LO  = 2'd0, // inst[4:2]
        DST_MID = 2'd1, // inst[7:5]
        DST_HI  = 2'd2, // inst[10:8]
        DST_R7  = 2'd3
    } dstReg_e;

    // Immediate width before extension
    typedef enum logic [1:0] {
        EXT_5  = 2'd0,
        EXT_8  = 2'd1,
        EXT_11 = 2'd2
    } extOp_e;

    typedef enum logic [2:0] {
        BR_EQZ   = 3'd0,
        BR_NEZ   = 3'd1,
        BR_LTZ   = 3'd2,
        BR_GEZ   = 3'd3,
        JMP_J    = 3'd4,
        JMP_JR   = 3'd5,
        JMP_JAL  = 3'd6,
        JMP_JALR = 3'd7
    } brJmpOp_e;

    function automatic opcode_e opcodeOf(input logic [instWidth-1:0] inst);
        return opcode_e'(inst[instWidth-1 -: opWidth]);
    endfunction

endpackage

//--- rtl/execControl.sv
module execControl import ctrlPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [instWidth-1:0] inst,
    output aluOp_e               aluOp,
    output logic                 aluSrc,
    output logic                 extSign,
    output extOp_e               extOp,
    output logic                 invR1,
    output logic                 invR2,
    output logic                 sign,
    output logic                 cin
);

    opcode_e   op;
    aluFunct_e funct;
    aluOp_e    aluOpNext;
    extOp_e    extOpNext;
    logic      aluSrcNext;
    logic      extSignNext;
    logic      invR1Next;
    logic      invR2Next;
    logic      signNext;
    logic      cinNext;

    assign op    = opcodeOf(inst);
    assign funct = aluFunct_e'(inst[functWidth-1:0]);

    always_comb begin
        aluOpNext   = ALU_ROL;
        aluSrcNext  = 1'b0;
        extSignNext = 1'b0;
        extOpNext   = EXT_5;
        invR1Next   = 1'b0;
        invR2Next   = 1'b0;
        signNext    = 1'b0;
        cinNext     = 1'b0;
        case (op)
            ADDI, ST, LD, STU: begin // Address calc is an add too
                aluOpNext   = ALU_ADD;
                aluSrcNext  = 1'b1;
                extSignNext = 1'b1;
                signNext    = 1'b1;
            end
            SUBI: begin
                aluOpNext   = ALU_SUB;
                aluSrcNext  = 1'b1;
                extSignNext = 1'b1;
                signNext    = 1'b1;
                invR1Next   = 1'b1; // imm - rs
                cinNext     = 1'b1;
            end
            XORI: begin
                aluOpNext  = ALU_XOR;
                aluSrcNext = 1'b1;
            end
            ANDNI: begin
                aluOpNext  = ALU_ANDN;
                aluSrcNext = 1'b1;
                invR2Next  = 1'b1;
            end
            ROLI, SLLI, RORI, SRLI: begin
                aluOpNext  = aluOp_e'({2'b00, inst[12:11]}); // Shift kind in opcode low bits
                aluSrcNext = 1'b1;
            end
            BALU: begin
                signNext = 1'b1;
                case (funct)
                    FN_ADD_ROL:  aluOpNext = ALU_ADD;
                    FN_SUB_SLL: begin
                        aluOpNext = ALU_SUB;
                        invR1Next = 1'b1;
                        cinNext   = 1'b1;
                    end
                    FN_XOR_ROR:  aluOpNext = ALU_XOR;
                    FN_ANDN_SRL: begin
                        aluOpNext = ALU_ANDN;
                        invR2Next = 1'b1;
                    end
                endcase
            end
            SALU: begin
                case (funct)
                    FN_ADD_ROL:  aluOpNext = ALU_ROL;
                    FN_SUB_SLL:  aluOpNext = ALU_SLL;
                    FN_XOR_ROR:  aluOpNext = ALU_ROR;
                    FN_ANDN_SRL: aluOpNext = ALU_SRL;
                endcase
            end
            SEQ, SLT, SLE: begin
                // Compare as rs - rt
                if (op == SEQ)
                    aluOpNext = ALU_SEQ;
                else if (op == SLT)
                    aluOpNext = ALU_SLT;
                else
                    aluOpNext = ALU_SLE;
                invR2Next = 1'b1;
                signNext  = 1'b1;
                cinNext   = 1'b1;
            end
            SCO: begin
                aluOpNext = ALU_SCO;
                signNext  = 1'b1;
            end
            BTR:  aluOpNext = ALU_BTR;
            LBI, SLBI: begin
                aluOpNext   = (op == LBI) ? ALU_LBI : ALU_SLBI;
                aluSrcNext  = 1'b1;
                extSignNext = 1'b1;
                extOpNext   = EXT_8;
            end
            BEQZ, BNEZ, BLTZ, BGEZ, JR, JALR: begin
                extSignNext = 1'b1;
                extOpNext   = EXT_8;
            end
            JDIS, JALC: begin
                extSignNext = 1'b1;
                extOpNext   = EXT_11; // Long displacement
            end
            HALT, NOP, ILLOP, RTI: ; // ALU idle
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluOp   <= ALU_ROL;
            aluSrc  <= 1'b0;
            extSign <= 1'b0;
            extOp   <= EXT_5;
            invR1   <= 1'b0;
            invR2   <= 1'b0;
            sign    <= 1'b0;
            cin     <= 1'b0;
        end else begin
            aluOp   <= aluOpNext;
            aluSrc  <= aluSrcNext;
            extSign <= extSignNext;
            extOp   <= extOpNext;
            invR1   <= invR1Next;
            invR2   <= invR2Next;
            sign    <= signNext;
            cin     <= cinNext;
        end
    end

endmodule

//--- rtl/flowControl.sv
module flowControl import ctrlPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [instWidth-1:0] inst,
    output pcSrc_e               pcSrc,
    output brJmpOp_e             brJmpOp,
    output logic                 jump,
    output logic                 branch,
    output logic                 excp
);

    opcode_e  op;
    pcSrc_e   pcSrcNext;
    brJmpOp_e brJmpOpNext;
    logic     jumpNext;
    logic     branchNext;
    logic     excpNext;

    assign op = opcodeOf(inst);

    always_comb begin
        pcSrcNext   = PC_INC;
        brJmpOpNext = BR_EQZ;
        jumpNext    = 1'b0;
        branchNext  = 1'b0;
        excpNext    = 1'b0;
        case (op)
            HALT: pcSrcNext = PC_OLD; // Stall on current PC
            BEQZ, BNEZ, BLTZ, BGEZ: begin
                pcSrcNext   = PC_TARGET;
                branchNext  = 1'b1;
                brJmpOpNext = brJmpOp_e'({1'b0, inst[12:11]}); // Condition from opcode
            end
            JDIS, JR, JALC, JALR: begin
                pcSrcNext   = PC_TARGET;
                jumpNext    = 1'b1;
                brJmpOpNext = brJmpOp_e'({1'b1, inst[12:11]});
            end
            ILLOP: begin
                pcSrcNext = PC_EPC;
                excpNext  = 1'b1;
            end
            RTI:  pcSrcNext = PC_EPC; // Return from handler
            NOP, ADDI, SUBI, XORI, ANDNI,
            ROLI, SLLI, RORI, SRLI,
            ST, LD, STU, LBI, SLBI,
            BTR, BALU, SALU, SEQ, SLT, SLE, SCO: pcSrcNext = PC_INC;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcSrc   <= PC_OLD;
            brJmpOp <= BR_EQZ;
            jump    <= 1'b0;
            branch  <= 1'b0;
            excp    <= 1'b0;
        end else begin
            pcSrc   <= pcSrcNext;
            brJmpOp <= brJmpOpNext;
            jump    <= jumpNext;
            branch  <= branchNext;
            excp    <= excpNext;
        end
    end

endmodule

//--- rtl/resultControl.sv
module resultControl import ctrlPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [instWidth-1:0] inst,
    output dstReg_e              dstReg,
    output logic                 regWrite,
    output logic                 jal,
    output logic                 memReg,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 memEn
);

    opcode_e op;
    dstReg_e dstRegNext;
    logic    regWriteNext;
    logic    jalNext;
    logic    memRegNext;
    logic    memReadNext;
    logic    memWriteNext;
    logic    memEnNext;

    assign op = opcodeOf(inst);

    always_comb begin
        dstRegNext   = DST_LO;
        regWriteNext = 1'b0;
        jalNext      = 1'b0;
        memRegNext   = 1'b0;
        memReadNext  = 1'b0;
        memWriteNext = 1'b0;
        memEnNext    = 1'b1;
        case (op)
            ADDI, SUBI, XORI, ANDNI,
            ROLI, SLLI, RORI, SRLI: begin
                dstRegNext   = DST_MID;
                regWriteNext = 1'b1;
            end
            ST: begin
                dstRegNext   = DST_MID;
                memWriteNext = 1'b1;
            end
            LD: begin
                dstRegNext   = DST_MID;
                regWriteNext = 1'b1;
                memReadNext  = 1'b1;
                memRegNext   = 1'b1; // Write back load data
            end
            STU: begin
                dstRegNext   = DST_MID;
                regWriteNext = 1'b1; // Base register update
                memWriteNext = 1'b1;
            end
            BTR, BALU, SALU, SEQ, SLT, SLE, SCO: regWriteNext = 1'b1;
            LBI, SLBI: begin
                dstRegNext   = DST_HI;
                regWriteNext = 1'b1;
            end
            JALC, JALR: begin
                // Link address into r7
                dstRegNext   = DST_R7;
                regWriteNext = 1'b1;
                jalNext      = 1'b1;
            end
            HALT: memEnNext = 1'b0;
            NOP, ILLOP, RTI,
            BEQZ, BNEZ, BLTZ, BGEZ, JDIS, JR: ; // No result
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dstReg   <= DST_LO;
            regWrite <= 1'b0;
            jal      <= 1'b0;
            memReg   <= 1'b0;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            memEn    <= 1'b0;
        end else begin
            dstReg   <= dstRegNext;
            regWrite <= regWriteNext;
            jal      <= jalNext;
            memReg   <= memRegNext;
            memRead  <= memReadNext;
            memWrite <= memWriteNext;
            memEn    <= memEnNext;
        end
    end

endmodule

//--- rtl/controlUnit.sv
module controlUnit import ctrlPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [instWidth-1:0] inst,
    output aluOp_e               aluOp,
    output logic                 aluSrc,
    output logic                 extSign,
    output extOp_e               extOp,
    output logic                 invR1,
    output logic                 invR2,
    output logic                 sign,
    output logic                 cin,
    output pcSrc_e               pcSrc,
    output brJmpOp_e             brJmpOp,
    output logic                 jump,
    output logic                 branch,
    output logic                 excp,
    output dstReg_e              dstReg,
    output logic                 regWrite,
    output logic                 jal,
    output logic                 memReg,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 memEn
);

    // ALU fields
    execControl uExec (
        .clk     (clk),
        .arstN   (arstN),
        .inst    (inst),
        .aluOp   (aluOp),
        .aluSrc  (aluSrc),
        .extSign (extSign),
        .extOp   (extOp),
        .invR1   (invR1),
        .invR2   (invR2),
        .sign    (sign),
        .cin     (cin)
    );

    // Next PC selection
    flowControl uFlow (
        .clk     (clk),
        .arstN   (arstN),
        .inst    (inst),
        .pcSrc   (pcSrc),
        .brJmpOp (brJmpOp),
        .jump    (jump),
        .branch  (branch),
        .excp    (excp)
    );

    resultControl uResult (
        .clk      (clk),
        .arstN    (arstN),
        .inst     (inst),
        .dstReg   (dstReg),
        .regWrite (regWrite),
        .jal      (jal),
        .memReg   (memReg),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memEn    (memEn)
    );

endmodule

//--- tests/ctrlRefModel.svh
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

typedef struct packed {
    aluOp_e   aluOp;
    logic     aluSrc;
    logic     extSign;
    extOp_e   extOp;
    logic     invR1;
    logic     invR2;
    logic     sign;
    logic     cin;
    pcSrc_e   pcSrc;
    brJmpOp_e brJmpOp;
    logic     jump;
    logic     branch;
    logic     excp;
    dstReg_e  dstReg;
    logic     regWrite;
    logic     jal;
    logic     memReg;
    logic     memRead;
    logic     memWrite;
    logic     memEn;
} ctrlFields_t;

// Expected control fields built field by field from the ISA rules
function automatic ctrlFields_t expectedFields(input logic [instWidth-1:0] word);
    opcode_e     op;
    logic [1:0]  fn;
    logic        immAlu;
    logic        memOp;
    logic        isBranch;
    logic        isJump;
    logic        baluSub;
    ctrlFields_t f;
    op       = opcodeOf(word);
    fn       = word[1:0];
    immAlu   = (op inside {ADDI, SUBI, XORI, ANDNI, ROLI, SLLI, RORI, SRLI});
    memOp    = (op inside {ST, LD, STU});
    isBranch = (op inside {BEQZ, BNEZ, BLTZ, BGEZ});
    isJump   = (op inside {JDIS, JR, JALC, JALR});
    baluSub  = (op == BALU) && (fn == 2'd1);
    f = '0;

    case (op)
        ADDI, ST, LD, STU: f.aluOp = ALU_ADD; // Address is base plus offset
        SUBI:  f.aluOp = ALU_SUB;
        XORI:  f.aluOp = ALU_XOR;
        ANDNI: f.aluOp = ALU_ANDN;
        ROLI:  f.aluOp = ALU_ROL;
        SLLI:  f.aluOp = ALU_SLL;
        RORI:  f.aluOp = ALU_ROR;
        SRLI:  f.aluOp = ALU_SRL;
        BALU: begin
            f.aluOp = (fn == 2'd0) ? ALU_ADD :
                      (fn == 2'd1) ? ALU_SUB :
                      (fn == 2'd2) ? ALU_XOR : ALU_ANDN;
        end
        SALU:  f.aluOp = aluOp_e'({2'b00, fn}); // Shift codes 0 to 3
        SEQ:   f.aluOp = ALU_SEQ;
        SLT:   f.aluOp = ALU_SLT;
        SLE:   f.aluOp = ALU_SLE;
        SCO:   f.aluOp = ALU_SCO;
        BTR:   f.aluOp = ALU_BTR;
        LBI:   f.aluOp = ALU_LBI;
        SLBI:  f.aluOp = ALU_SLBI;
        default: f.aluOp = ALU_ROL;
    endcase

    f.aluSrc  = immAlu || memOp || (op inside {LBI, SLBI});
    f.extSign = (op inside {ADDI, SUBI, LBI, SLBI}) || memOp || isBranch || isJump;
    f.extOp   = (op inside {JDIS, JALC}) ? EXT_11 :
                (isBranch || (op inside {LBI, SLBI, JR, JALR})) ? EXT_8 : EXT_5;
    f.invR1   = (op == SUBI) || baluSub;
    f.invR2   = (op == ANDNI) || ((op == BALU) && (fn == 2'd3)) || (op inside {SEQ, SLT, SLE});
    f.sign    = (op inside {ADDI, SUBI, BALU, SEQ, SLT, SLE, SCO}) || memOp;
    f.cin     = (op == SUBI) || baluSub || (op inside {SEQ, SLT, SLE});

    f.pcSrc = (op == HALT) ? PC_OLD :
              (isBranch || isJump) ? PC_TARGET :
              (op inside {ILLOP, RTI}) ? PC_EPC : PC_INC;
    case (op)
        BEQZ: f.brJmpOp = BR_EQZ;
        BNEZ: f.brJmpOp = BR_NEZ;
        BLTZ: f.brJmpOp = BR_LTZ;
        BGEZ: f.brJmpOp = BR_GEZ;
        JDIS: f.brJmpOp = JMP_J;
        JR:   f.brJmpOp = JMP_JR;
        JALC: f.brJmpOp = JMP_JAL;
        JALR: f.brJmpOp = JMP_JALR;
        default: f.brJmpOp = BR_EQZ;
    endcase
    f.jump   = isJump;
    f.branch = isBranch;
    f.excp   = (op == ILLOP);

    f.dstReg = (immAlu || memOp) ? DST_MID :
               (op inside {LBI, SLBI}) ? DST_HI :
               (op inside {JALC, JALR}) ? DST_R7 : DST_LO;
    f.regWrite = immAlu || (op inside {BTR, BALU, SALU, SEQ, SLT, SLE, SCO,
                                       LD, STU, LBI, SLBI, JALC, JALR});
    f.jal      = (op inside {JALC, JALR});
    f.memReg   = (op == LD);
    f.memRead  = (op == LD);
    f.memWrite = (op inside {ST, STU});
    f.memEn    = (op != HALT);
    return f;
endfunction

`endif

//--- tests/controlUnitTb.sv
module controlUnitTb import ctrlPkg::*; ();

    `include "ctrlRefModel.svh"

    localparam int clkPeriod    = 40;
    localparam int resetCycles  = 3;
    localparam int numDirected  = 38;
    localparam int numRandom    = 400;
    localparam int watchdogTime = (numDirected + numRandom + resetCycles + 20) * clkPeriod;

    logic                 clk;
    logic                 arstN;
    logic [instWidth-1:0] inst;
    aluOp_e               aluOp;
    logic                 aluSrc;
    logic                 extSign;
    extOp_e               extOp;
    logic                 invR1;
    logic                 invR2;
    logic                 sign;
    logic                 cin;
    pcSrc_e               pcSrc;
    brJmpOp_e             brJmpOp;
    logic                 jump;
    logic                 branch;
    logic                 excp;
    dstReg_e              dstReg;
    logic                 regWrite;
    logic                 jal;
    logic                 memReg;
    logic                 memRead;
    logic                 memWrite;
    logic                 memEn;

    int                   seed = 79701;
    int                   errCount = 0;
    int                   checkCount = 0;
    int                   passCount = 0;
    int                   failCount = 0;
    logic                 armed = 1'b0;
    logic                 prevValid = 1'b0;
    logic [instWidth-1:0] prevInst = '0;

    controlUnit DUT (
        .clk      (clk),
        .arstN    (arstN),
        .inst     (inst),
        .aluOp    (aluOp),
        .aluSrc   (aluSrc),
        .extSign  (extSign),
        .extOp    (extOp),
        .invR1    (invR1),
        .invR2    (invR2),
        .sign     (sign),
        .cin      (cin),
        .pcSrc    (pcSrc),
        .brJmpOp  (brJmpOp),
        .jump     (jump),
        .branch   (branch),
        .excp     (excp),
        .dstReg   (dstReg),
        .regWrite (regWrite),
        .jal      (jal),
        .memReg   (memReg),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memEn    (memEn)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [instWidth-1:0] randomInst(input opcode_e op);
        return {op, 11'($random(seed))};
    endfunction

    // R-format keeps the function field and randomizes the register fields
    function automatic logic [instWidth-1:0] rFormat(input opcode_e op, input logic [1:0] fn);
        logic [10:0] fill;
        fill = 11'($random(seed));
        return {op, fill[10:2], fn};
    endfunction

    task automatic checkCode(input string name, input logic [3:0] got, input logic [3:0] want);
        checkCount++;
        assert (got === want)
        else begin
            $display("Mismatch at time %0t: %s is %0h, expected %0h (inst %h)",
                     $time, name, got, want, prevInst);
            errCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic want);
        checkCode(name, {3'b000, got}, {3'b000, want});
    endtask

    task automatic compareOutputs(input ctrlFields_t want);
        checkCode("aluOp", aluOp, want.aluOp);
        checkBit("aluSrc", aluSrc, want.aluSrc);
        checkBit("extSign", extSign, want.extSign);
        checkCode("extOp", 4'(extOp), 4'(want.extOp));
        checkBit("invR1", invR1, want.invR1);
        checkBit("invR2", invR2, want.invR2);
        checkBit("sign", sign, want.sign);
        checkBit("cin", cin, want.cin);
        checkCode("pcSrc", 4'(pcSrc), 4'(want.pcSrc));
        checkCode("brJmpOp", 4'(brJmpOp), 4'(want.brJmpOp));
        checkBit("jump", jump, want.jump);
        checkBit("branch", branch, want.branch);
        checkBit("excp", excp, want.excp);
        checkCode("dstReg", 4'(dstReg), 4'(want.dstReg));
        checkBit("regWrite", regWrite, want.regWrite);
        checkBit("jal", jal, want.jal);
        checkBit("memReg", memReg, want.memReg);
        checkBit("memRead", memRead, want.memRead);
        checkBit("memWrite", memWrite, want.memWrite);
        checkBit("memEn", memEn, want.memEn);
    endtask

    // Outputs seen at an edge belong to the inst captured one edge earlier
    always @(posedge clk) begin
        ctrlFields_t want;
        if (armed) begin
            if (prevValid)
                want = expectedFields(prevInst);
            else
                want = '0; // Reset value up to the first edge after release
            compareOutputs(want);
        end
        if (!arstN) begin
            armed     = 1'b1;
            prevValid = 1'b0;
        end else begin
            prevValid = 1'b1;
            prevInst  = inst;
        end
    end

    task automatic applyInst(input logic [instWidth-1:0] value);
        inst = value;
        @(negedge clk);
    endtask

    task automatic reportTest(input string name, input int errs);
        if (errs == 0) begin
            passCount++;
            $display("PASS  %s", name);
        end else begin
            failCount++;
            $display("FAIL  %s, %0d mismatches", name, errs);
        end
    endtask

    task automatic runTest(input string name, input logic [instWidth-1:0] insts[$]);
        int errBefore;
        errBefore = errCount;
        foreach (insts[k])
            applyInst(insts[k]);
        @(negedge clk); // Last decode gets checked
        reportTest(name, errCount - errBefore);
    endtask

    initial begin
        logic [instWidth-1:0] insts[$];
        int                   i;
        arstN = 1'b0;
        inst  = 16'($random(seed)); // Reset must mask this
        repeat (resetCycles) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        reportTest("reset", errCount);

        insts = '{randomInst(ADDI), randomInst(SUBI), randomInst(XORI), randomInst(ANDNI),
                  randomInst(ROLI), randomInst(SLLI), randomInst(RORI), randomInst(SRLI),
                  randomInst(SEQ), randomInst(SLT), randomInst(SLE), randomInst(SCO),
                  randomInst(BTR), randomInst(LBI), randomInst(SLBI)};
        for (i = 0; i < 4; i++) begin
            insts.push_back(rFormat(BALU, 2'(i)));
            insts.push_back(rFormat(SALU, 2'(i)));
        end
        runTest("ALU ops", insts);

        insts = '{randomInst(BEQZ), randomInst(BNEZ), randomInst(BLTZ), randomInst(BGEZ),
                  randomInst(JDIS), randomInst(JR), randomInst(JALC), randomInst(JALR)};
        runTest("branches and jumps", insts);

        insts = '{randomInst(LD), randomInst(ST), randomInst(STU)};
        runTest("memory ops", insts);

        insts = '{randomInst(HALT), randomInst(NOP), randomInst(ILLOP), randomInst(RTI)};
        runTest("special opcodes", insts);

        insts = {};
        for (i = 0; i < numRandom; i++)
            insts.push_back(16'($random(seed)));
        runTest("back-to-back sweep", insts);

        $display("Tests passed %0d, failed %0d, field checks %0d, mismatches %0d",
                 passCount, failCount, checkCount, errCount);
        if (failCount == 0 && errCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        #(watchdogTime);
        $display("Timeout: the tests did not finish within %0d time units", watchdogTime);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
common/ctrlPkg.sv
rtl/execControl.sv
rtl/flowControl.sv
rtl/resultControl.sv
rtl/controlUnit.sv
tests/controlUnitTb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := controlUnitTb
FILELIST := verilog.f
BUILDDIR := obj_dir
LOG      := sim.log
PASSMSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) || (echo "Test run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)
